/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal -Mdir obj_dir
TOP       ?= tbBranchPredictor
FILELIST  ?= vlog.f
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG) || ! grep -q "Testbench passed" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* branchPatternTable.sv */
`default_nettype none

module branchPatternTable
    import branchPkg::*;
(
    input  wire                  clk,
    input  wire                  rst,

    input  wire [bptIdxBits-1:0] lookupIdx,

    input  wire                  bpUpdValid,
    input  wire [30:0]           bpUpdSrc,
    input  wire                  bpUpdTaken,

    output logic                 bptTaken
);

    logic [1:0]            cnt [bptEntries];
    logic [bptIdxBits-1:0] sweepIdx;
    logic                  sweepBusy;
    logic [bptIdxBits-1:0] updIdx;
    logic [1:0]            updCnt;
    logic [1:0]            nextCnt;

    assign updIdx = bpUpdSrc[bptIdxBits-1:0];
    assign updCnt = cnt[updIdx];

    always_comb begin
        nextCnt = updCnt;
        if (bpUpdTaken && updCnt != 2'b11)
            nextCnt = updCnt + 2'd1;
        else if (!bpUpdTaken && updCnt != 2'b00)
            nextCnt = updCnt - 2'd1;
    end

    // init sweep, one counter per cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            sweepIdx <= '0;
            sweepBusy <= 1'b1;
        end else if (sweepBusy) begin
            sweepIdx <= sweepIdx + 1'b1;
            if (sweepIdx == bptIdxBits'(bptEntries - 1))
                sweepBusy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (sweepBusy)
            cnt[sweepIdx] <= bptInit;
        else if (bpUpdValid)
            cnt[updIdx] <= nextCnt;
    end

    assign bptTaken = !sweepBusy && cnt[lookupIdx][1]; // not taken while sweeping.

    // pushing a saturated counter further leaves it where it is.
    aNoWrap: assert property (@(posedge clk) disable iff (rst)
        (!sweepBusy && bpUpdValid && updCnt == {2{bpUpdTaken}})
        |=> cnt[$past(updIdx)] == $past(updCnt));

endmodule

`default_nettype wire

/* branchPkg.sv */
`default_nettype none

package branchPkg;

    // btb geometry.
    localparam int btbEntries = 32;
    localparam int btbAssoc = 2;
    localparam int btbSets = btbEntries / btbAssoc;
    localparam int btbSetBits = $clog2(btbSets);
    localparam int btbWayBits = $clog2(btbAssoc);

    // halfword address bits kept as source tag, low 3 are the block offset.
    localparam int btbTagSize = 14;

    // counter table.
    localparam int bptEntries = 256;
    localparam int bptIdxBits = $clog2(bptEntries);

    localparam logic [1:0] bptInit = 2'b01; // weakly not taken.

    // halfword offset inside an eight-halfword fetch block.
    typedef logic [2:0] FetchOff;

endpackage

`default_nettype wire

/* branchPredictor.sv */
`default_nettype none

module branchPredictor
    import branchPkg::*;
(
    input  wire         clk,
    input  wire         rst,

    // fetch side.
    input  wire         pcValid,
    input  wire         redirect,
    input  wire [30:0]  redirectPc,
    output logic [30:0] pc,
    output logic        branchFound,
    output logic [30:0] branchDst,
    output FetchOff     branchSrcOffs,
    output logic        branchIsJump,
    output logic        branchCompr,
    output logic        multipleBranches,
    output logic        predTaken,

    // btb update from the backend.
    input  wire         btUpdValid,
    input  wire [31:0]  btUpdSrc,
    input  wire [31:0]  btUpdDst,
    input  wire         btUpdIsJump,
    input  wire         btUpdCompr,
    input  wire         btUpdClean,

    // counter update from the backend.
    input  wire         bpUpdValid,
    input  wire [30:0]  bpUpdSrc,
    input  wire         bpUpdTaken
);

    logic                  bptTaken;
    logic [bptIdxBits-1:0] lookupIdx;

    assign lookupIdx = {pc[bptIdxBits-1:3], branchSrcOffs}; // source halfword of the hit.

    branchTargetBuffer btb (
        .clk(clk),
        .rst(rst),
        .pcValid(pcValid),
        .pc(pc),
        .bptTaken(bptTaken),
        .btUpdValid(btUpdValid),
        .btUpdSrc(btUpdSrc),
        .btUpdDst(btUpdDst),
        .btUpdIsJump(btUpdIsJump),
        .btUpdCompr(btUpdCompr),
        .btUpdClean(btUpdClean),
        .branchFound(branchFound),
        .branchDst(branchDst),
        .branchSrcOffs(branchSrcOffs),
        .branchIsJump(branchIsJump),
        .branchCompr(branchCompr),
        .multipleBranches(multipleBranches)
    );

    branchPatternTable bpt (
        .clk(clk),
        .rst(rst),
        .lookupIdx(lookupIdx),
        .bpUpdValid(bpUpdValid),
        .bpUpdSrc(bpUpdSrc),
        .bpUpdTaken(bpUpdTaken),
        .bptTaken(bptTaken)
    );

    fetchPcGen pcGen (
        .clk(clk),
        .rst(rst),
        .pcValid(pcValid),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .branchFound(branchFound),
        .branchIsJump(branchIsJump),
        .bptTaken(bptTaken),
        .branchDst(branchDst),
        .pc(pc),
        .predTaken(predTaken)
    );

endmodule

`default_nettype wire

/* branchTargetBuffer.sv */
`default_nettype none

module branchTargetBuffer
    import branchPkg::*;
(
    input  wire              clk,
    input  wire              rst,

    input  wire              pcValid,
    input  wire [30:0]       pc,
    input  wire              bptTaken,

    input  wire              btUpdValid,
    input  wire [31:0]       btUpdSrc,
    input  wire [31:0]       btUpdDst,
    input  wire              btUpdIsJump,
    input  wire              btUpdCompr,
    input  wire              btUpdClean,

    output logic             branchFound,
    output logic [30:0]      branchDst,
    output FetchOff          branchSrcOffs,
    output logic             branchIsJump,
    output logic             branchCompr,
    output logic             multipleBranches
);

    logic                  entValid [btbSets][btbAssoc];
    logic                  entUsed  [btbSets][btbAssoc];
    logic                  entJump  [btbSets][btbAssoc];
    logic                  entCompr [btbSets][btbAssoc];
    logic [30:0]           entDst   [btbSets][btbAssoc];
    logic [btbTagSize-1:0] entSrc   [btbSets][btbAssoc];

    logic [btbSetBits-1:0] lookIdx;
    logic [btbSetBits-1:0] updIdx;
    logic [btbWayBits-1:0] hitWay;
    logic [btbWayBits-1:0] insWay;
    logic                  insOk;
    logic [btbAssoc-1:0]   clrUsed;

    assign lookIdx = pc[btbSetBits+2:3];
    assign updIdx = btUpdSrc[btbSetBits+3:4]; // byte address, one bit higher.

    // earliest branch at or after the fetch offset.
    always_comb begin
        branchFound = 1'b0;
        multipleBranches = 1'b0;
        branchDst = '0;
        branchIsJump = 1'b0;
        branchCompr = 1'b0;
        branchSrcOffs = '0;
        hitWay = '0;
        if (pcValid) begin
            for (int w = 0; w < btbAssoc; w++) begin
                if (entValid[lookIdx][w] &&
                    entSrc[lookIdx][w][btbTagSize-1:3] == pc[btbTagSize-1:3] &&
                    entSrc[lookIdx][w][2:0] >= pc[2:0] &&
                    (!branchFound || entSrc[lookIdx][w][2:0] < branchSrcOffs)) begin
                    multipleBranches = branchFound;
                    branchFound = 1'b1;
                    branchDst = entDst[lookIdx][w];
                    branchIsJump = entJump[lookIdx][w];
                    branchCompr = entCompr[lookIdx][w];
                    branchSrcOffs = entSrc[lookIdx][w][2:0];
                    hitWay = btbWayBits'(w);
                end
            end
        end
    end

    // victim choice, invalid ways first, then ways not recently used.
    always_comb begin
        insOk = 1'b0;
        insWay = '0;
        clrUsed = '0;
        for (int w = 0; w < btbAssoc; w++) begin
            if (!insOk) begin
                clrUsed[w] = 1'b1; // skipped ways lose their used bit.
                if (!entValid[updIdx][w]) begin
                    insOk = 1'b1;
                    insWay = btbWayBits'(w);
                end
            end
        end
        for (int w = 0; w < btbAssoc; w++) begin
            if (!insOk && !entUsed[updIdx][w]) begin
                insOk = 1'b1;
                insWay = btbWayBits'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < btbSets; s++) begin
                for (int w = 0; w < btbAssoc; w++) begin
                    entValid[s][w] <= 1'b0;
                    entUsed[s][w] <= 1'b0;
                end
            end
        end else begin
            if (btUpdValid && btUpdClean) begin
                for (int w = 0; w < btbAssoc; w++)
                    entValid[updIdx][w] <= 1'b0;
            end else if (btUpdValid) begin
                for (int w = 0; w < btbAssoc; w++) begin
                    if (clrUsed[w])
                        entUsed[updIdx][w] <= 1'b0;
                end
                if (insOk)
                    entValid[updIdx][insWay] <= 1'b1;
            end
            // later write wins if this hits the freshly cleared way.
            if (pcValid && branchFound && (bptTaken || branchIsJump))
                entUsed[lookIdx][hitWay] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (btUpdValid && !btUpdClean && insOk) begin
            entJump[updIdx][insWay] <= btUpdIsJump;
            entCompr[updIdx][insWay] <= btUpdCompr;
            entDst[updIdx][insWay] <= btUpdDst[31:1];
            entSrc[updIdx][insWay] <= btUpdSrc[btbTagSize:1];
        end
    end

    aNoHitAfterReset: assert property (@(posedge clk) rst |=> !branchFound);

    aMultiImpliesFound: assert property (@(posedge clk) disable iff (rst)
        multipleBranches |-> branchFound);

endmodule

`default_nettype wire

/* fetchPcGen.sv */
`default_nettype none

module fetchPcGen
    import branchPkg::*;
(
    input  wire         clk,
    input  wire         rst,

    input  wire         pcValid,
    input  wire         redirect,
    input  wire [30:0]  redirectPc,

    input  wire         branchFound,
    input  wire         branchIsJump,
    input  wire         bptTaken,
    input  wire [30:0]  branchDst,

    output logic [30:0] pc,
    output logic        predTaken
);

    logic [30:0]        seqPc;
    logic [30:0]        nextPc;

    assign predTaken = branchFound && (branchIsJump || bptTaken);

    // next block base, offset dropped.
    assign seqPc = {pc[30:3] + 28'd1, 3'b000};

    always_comb begin
        nextPc = pc; // stall.
        if (redirect)
            nextPc = redirectPc;
        else if (pcValid && predTaken)
            nextPc = branchDst;
        else if (pcValid)
            nextPc = seqPc;
    end

    always_ff @(posedge clk) begin
        if (rst)
            pc <= '0;
        else
            pc <= nextPc;
    end

    aPcHolds: assert property (@(posedge clk) disable iff (rst)
        (!pcValid && !redirect) |=> $stable(pc));

endmodule

`default_nettype wire

/* tbBranchPredictor.sv */
`default_nettype none

module tbBranchPredictor
    import branchPkg::*;
();

    localparam int period = 100;
    localparam int drvDelay = 5;
    localparam int sweepCycles = bptEntries + 10;
    // reset, insert, prediction, replacement, clean, redirect.
    localparam int cycleBudget = 20 + 40 + 80 + 50 + 60 + 40;

    logic clk, rst;
    logic pcValid, redirect;
    logic [30:0] redirectPc, pc, branchDst;
    logic branchFound, branchIsJump, branchCompr, multipleBranches, predTaken;
    FetchOff branchSrcOffs;
    logic btUpdValid, btUpdIsJump, btUpdCompr, btUpdClean;
    logic [31:0] btUpdSrc, btUpdDst;
    logic bpUpdValid, bpUpdTaken;
    logic [30:0] bpUpdSrc;

    // expected lookup result, set by the stimulus.
    logic expFound, expJump, expCompr, expMulti, expPred;
    logic [30:0] expDst, expPc;
    FetchOff expOffs;
    logic [1:0] modelCnt [bptEntries];

    logic [31:0] lcgState = 32'h561708ae;
    int errCount = 0;
    int errMark = 0;
    int testCount = 0;
    int failCount = 0;

    branchPredictor uut (.*);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        #((cycleBudget + sweepCycles) * period);
        $display("timeout: the tests did not finish within %0d cycles",
            cycleBudget + sweepCycles);
        $display("Testbench failed");
        $finish;
    end

    // reference counters, saturating at 0 and 3.
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < bptEntries; i++)
                modelCnt[i] <= bptInit;
        end else if (bpUpdValid) begin
            if (bpUpdTaken && modelCnt[bpUpdSrc[bptIdxBits-1:0]] != 2'b11)
                modelCnt[bpUpdSrc[bptIdxBits-1:0]] <= modelCnt[bpUpdSrc[bptIdxBits-1:0]] + 2'd1;
            else if (!bpUpdTaken && modelCnt[bpUpdSrc[bptIdxBits-1:0]] != 2'b00)
                modelCnt[bpUpdSrc[bptIdxBits-1:0]] <= modelCnt[bpUpdSrc[bptIdxBits-1:0]] - 2'd1;
        end
    end

    assign expPred = expFound && (expJump || modelCnt[{expPc[bptIdxBits-1:3], expOffs}][1]);

    // reference pc register.
    always @(posedge clk) begin
        if (rst)
            expPc <= '0;
        else if (redirect)
            expPc <= redirectPc;
        else if (pcValid && expPred)
            expPc <= expDst;
        else if (pcValid)
            expPc <= {expPc[30:3] + 28'd1, 3'b000};
    end

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        errCount++;
        $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    endtask

    task automatic noteFailure(input string what);
        errCount++;
        $display("at %0t: %s", $time, what);
    endtask

    aPc: assert property (@(posedge clk) disable iff (rst) pc == expPc)
        else mismatch("pc", $sampled(pc), $sampled(expPc));
    aFound: assert property (@(posedge clk) disable iff (rst) pcValid |-> branchFound == expFound)
        else mismatch("branchFound", $sampled(branchFound), $sampled(expFound));
    aMulti: assert property (@(posedge clk) disable iff (rst)
        pcValid |-> multipleBranches == expMulti)
        else mismatch("multipleBranches", $sampled(multipleBranches), $sampled(expMulti));
    aPred: assert property (@(posedge clk) disable iff (rst) pcValid |-> predTaken == expPred)
        else mismatch("predTaken", $sampled(predTaken), $sampled(expPred));
    aDst: assert property (@(posedge clk) disable iff (rst)
        pcValid && expFound |-> branchDst == expDst)
        else mismatch("branchDst", $sampled(branchDst), $sampled(expDst));
    aOffs: assert property (@(posedge clk) disable iff (rst)
        pcValid && expFound |-> branchSrcOffs == expOffs)
        else mismatch("branchSrcOffs", $sampled(branchSrcOffs), $sampled(expOffs));
    aFlags: assert property (@(posedge clk) disable iff (rst)
        pcValid && expFound |-> {branchIsJump, branchCompr} == {expJump, expCompr})
        else mismatch("{branchIsJump,branchCompr}", $sampled({branchIsJump, branchCompr}),
            $sampled({expJump, expCompr}));
    aIdle: assert property (@(posedge clk) disable iff (rst)
        !pcValid |-> !branchFound && !predTaken && !multipleBranches)
        else noteFailure("lookup outputs active while pcValid is low");

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [30:0] randPc();
        logic [31:0] r;
        r = lcgNext();
        return r[30:0];
    endfunction

    function automatic logic [30:0] randBlock();
        logic [31:0] r;
        r = lcgNext();
        return {r[30:3], 3'b000};
    endfunction

    task automatic tick();
        @(posedge clk);
        #drvDelay;
    endtask

    task automatic insertBranch(input logic [30:0] src, input logic [30:0] dst,
                                input logic jmp, input logic compr);
        btUpdValid = 1'b1;
        btUpdClean = 1'b0;
        btUpdSrc = {src, 1'b0}; // halfword to byte address.
        btUpdDst = {dst, 1'b0};
        btUpdIsJump = jmp;
        btUpdCompr = compr;
        tick();
        btUpdValid = 1'b0;
    endtask

    task automatic cleanSet(input logic [30:0] src);
        btUpdValid = 1'b1;
        btUpdClean = 1'b1;
        btUpdSrc = {src, 1'b0};
        tick();
        btUpdValid = 1'b0;
        btUpdClean = 1'b0;
    endtask

    task automatic cleanAll();
        for (int s = 0; s < btbSets; s++)
            cleanSet(31'(s) << 3);
    endtask

    task automatic counterUpd(input logic [30:0] src, input logic taken);
        bpUpdValid = 1'b1;
        bpUpdSrc = src;
        bpUpdTaken = taken;
        tick();
        bpUpdValid = 1'b0;
    endtask

    task automatic expectHit(input logic [30:0] dst, input FetchOff offs,
                             input logic jmp, input logic compr, input logic multi);
        expFound = 1'b1;
        expDst = dst;
        expOffs = offs;
        expJump = jmp;
        expCompr = compr;
        expMulti = multi;
    endtask

    task automatic expectMiss();
        expFound = 1'b0;
        expMulti = 1'b0;
        expJump = 1'b0;
    endtask

    // redirect to addr, then one valid fetch cycle.
    task automatic fetchAt(input logic [30:0] addr);
        redirect = 1'b1;
        redirectPc = addr;
        tick();
        redirect = 1'b0;
        pcValid = 1'b1;
        tick();
        pcValid = 1'b0;
    endtask

    task automatic endTest(input string name);
        int errs;
        tick();
        errs = errCount - errMark;
        errMark = errCount;
        testCount++;
        if (errs != 0)
            failCount++;
        $display("%s: done, %0d errors", name, errs);
    endtask

    initial begin
        logic [30:0] a, b, c, d1, d2, d3, src;
        rst = 1'b1;
        pcValid = 1'b0;
        redirect = 1'b0;
        redirectPc = '0;
        btUpdValid = 1'b0;
        btUpdSrc = '0;
        btUpdDst = '0;
        btUpdIsJump = 1'b0;
        btUpdCompr = 1'b0;
        btUpdClean = 1'b0;
        bpUpdValid = 1'b0;
        bpUpdSrc = '0;
        bpUpdTaken = 1'b0;
        expectMiss();
        expCompr = 1'b0;
        expDst = '0;
        expOffs = '0;
        repeat (3) @(posedge clk);
        #drvDelay;
        rst = 1'b0;
        while (uut.bpt.sweepBusy)
            tick();

        pcValid = 1'b1; // empty btb, sequential fetch.
        repeat (4) tick();
        pcValid = 1'b0;
        repeat (3) tick();
        endTest("reset");

        a = randBlock();
        d1 = randPc();
        d2 = randPc();
        insertBranch(a + 31'd5, d1, 1'b0, 1'b1);
        expectHit(d1, 3'd5, 1'b0, 1'b1, 1'b0);
        fetchAt(a + 31'd2);
        fetchAt(a + 31'd5);
        expectMiss();
        fetchAt(a + 31'd6); // offset past the source.
        insertBranch(a + 31'd3, d2, 1'b1, 1'b0);
        expectHit(d2, 3'd3, 1'b1, 1'b0, 1'b1);
        fetchAt(a + 31'd1);
        expectHit(d1, 3'd5, 1'b0, 1'b1, 1'b0);
        fetchAt(a + 31'd4);
        redirect = 1'b1;
        redirectPc = a + 31'd1; // stalled on a block with two branches.
        tick();
        redirect = 1'b0;
        repeat (2) tick();
        endTest("insert and lookup");

        cleanAll();
        a = randBlock();
        b = a ^ 31'h8; // neighbouring set.
        d1 = randPc();
        d2 = randPc();
        insertBranch(a + 31'd2, d1, 1'b1, 1'b0);
        expectHit(d1, 3'd2, 1'b1, 1'b0, 1'b0);
        fetchAt(a);
        src = b + 31'd4;
        insertBranch(src, d2, 1'b0, 1'b0);
        expectHit(d2, 3'd4, 1'b0, 1'b0, 1'b0);
        fetchAt(b);
        counterUpd(src, 1'b1);
        fetchAt(b);
        repeat (2) counterUpd(src, 1'b0);
        fetchAt(b);
        repeat (4) counterUpd(src, 1'b1);
        fetchAt(b);
        counterUpd(src, 1'b0); // 3 down to 2, still taken.
        fetchAt(b);
        repeat (4) counterUpd(src, 1'b0);
        counterUpd(src, 1'b1);
        fetchAt(b);
        endTest("prediction");

        cleanAll();
        a = randBlock();
        b = a ^ 31'h80; // same set, other tag.
        c = a ^ 31'h100;
        d1 = randPc();
        d2 = randPc();
        d3 = randPc();
        insertBranch(a + 31'd1, d1, 1'b1, 1'b0);
        insertBranch(b + 31'd2, d2, 1'b0, 1'b0);
        expectHit(d1, 3'd1, 1'b1, 1'b0, 1'b0);
        fetchAt(a); // sets the used bit of way 0.
        insertBranch(c + 31'd3, d3, 1'b1, 1'b0);
        fetchAt(a);
        expectHit(d3, 3'd3, 1'b1, 1'b0, 1'b0);
        fetchAt(c);
        expectMiss();
        fetchAt(b);
        endTest("replacement");

        cleanAll();
        a = randBlock();
        b = a ^ 31'h80;
        c = a ^ 31'h8;
        d1 = randPc();
        d2 = randPc();
        d3 = randPc();
        insertBranch(a, d1, 1'b1, 1'b0);
        insertBranch(b + 31'd6, d2, 1'b1, 1'b0);
        insertBranch(c + 31'd7, d3, 1'b1, 1'b0);
        expectHit(d1, 3'd0, 1'b1, 1'b0, 1'b0);
        fetchAt(a);
        expectHit(d2, 3'd6, 1'b1, 1'b0, 1'b0);
        fetchAt(b);
        cleanSet(a);
        expectMiss();
        fetchAt(a);
        fetchAt(b);
        expectHit(d3, 3'd7, 1'b1, 1'b0, 1'b0);
        fetchAt(c);
        endTest("clean");

        cleanAll();
        a = randBlock();
        d1 = randPc();
        insertBranch(a + 31'd1, d1, 1'b1, 1'b1);
        redirect = 1'b1;
        redirectPc = a;
        tick();
        expectHit(d1, 3'd1, 1'b1, 1'b1, 1'b0);
        pcValid = 1'b1; // jump hit and redirect together.
        redirectPc = randPc();
        tick();
        redirect = 1'b0;
        pcValid = 1'b0;
        endTest("redirect");

        $display("tests run %0d, tests failed %0d, errors %0d", testCount, failCount, errCount);
        if (errCount == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
branchPkg.sv
branchTargetBuffer.sv
branchPatternTable.sv
fetchPcGen.sv
branchPredictor.sv
tbBranchPredictor.sv
